// File: hw/xbar_cfg_pkg.sv
// ========================================
// Crossbar configuration
// Port counts, bus widths and address map
// ========================================

package xbar_cfg_pkg;

  // Port counts
  localparam int unsigned N_MGR = 2;
  localparam int unsigned N_SUB = 2;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // ID widths, the subordinate side adds the manager index on top
  localparam int unsigned MGR_ID_W = 2;
  localparam int unsigned SUB_ID_W = MGR_ID_W + $clog2(N_MGR);

  // Address map, range ends are inclusive
  localparam logic [ADDR_W-1:0] SUB0_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] SUB0_END  = 32'h0000_FFFF;
  localparam logic [ADDR_W-1:0] SUB1_BASE = 32'h0001_0000;
  localparam logic [ADDR_W-1:0] SUB1_END  = 32'h0001_FFFF;

endpackage

// File: hw/axi_rd_pkg.sv
// ========================================
// AXI read channel types
// Response codes and the AR/R field types
// ========================================

package axi_rd_pkg;

  // RRESP encoding, only the codes this crossbar produces or forwards
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

  typedef logic [xbar_cfg_pkg::ADDR_W-1:0]   addr_t;
  typedef logic [xbar_cfg_pkg::DATA_W-1:0]   data_t;

  // Manager side ID
  typedef logic [xbar_cfg_pkg::MGR_ID_W-1:0] mgr_id_t;
  // Subordinate side ID, manager index in the top bit
  typedef logic [xbar_cfg_pkg::SUB_ID_W-1:0] sub_id_t;

endpackage

// File: hw/ar_r_if.sv
// ========================================
// AXI read address and read data channels
// ========================================

`timescale 1ns/1ns

interface ar_r_if #(
  parameter int unsigned ID_W = xbar_cfg_pkg::MGR_ID_W
) ();

  // AR channel
  logic              ar_valid;
  logic              ar_ready;
  logic [ID_W-1:0]   ar_id;
  axi_rd_pkg::addr_t ar_addr;

  // R channel, always a single beat
  logic              r_valid;
  logic              r_ready;
  logic [ID_W-1:0]   r_id;
  axi_rd_pkg::data_t r_data;
  axi_rd_pkg::resp_e r_resp;

  modport mgr (
    output ar_valid, ar_id, ar_addr, r_ready,
    input  ar_ready, r_valid, r_id, r_data, r_resp
  );

  modport sub (
    input  ar_valid, ar_id, ar_addr, r_ready,
    output ar_ready, r_valid, r_id, r_data, r_resp
  );

endinterface

// File: hw/addr_decoder.sv
// ========================================
// AR address decoder
// Picks the subordinate or flags DECERR
// ========================================

`timescale 1ns/1ns

module addr_decoder (
  input  axi_rd_pkg::addr_t addr_i,
  output logic              sub_idx_o,
  output logic              dec_err_o
);

  logic hit_0;
  logic hit_1;

  // Offset from base compared to range size, one unsigned compare per rule
  assign hit_0 = (addr_i - xbar_cfg_pkg::SUB0_BASE) <=
                 (xbar_cfg_pkg::SUB0_END - xbar_cfg_pkg::SUB0_BASE);
  assign hit_1 = (addr_i - xbar_cfg_pkg::SUB1_BASE) <=
                 (xbar_cfg_pkg::SUB1_END - xbar_cfg_pkg::SUB1_BASE);

  assign sub_idx_o = hit_1 && !hit_0;   // Rule 0 wins on overlap
  assign dec_err_o = !(hit_0 || hit_1);

endmodule

// File: hw/rd_demux.sv
// ========================================
// Manager side read demultiplexer
// One read in flight, routed by address
// ========================================

`timescale 1ns/1ns

module rd_demux (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                ar_valid_i,
  input  axi_rd_pkg::mgr_id_t ar_id_i,
  input  axi_rd_pkg::addr_t   ar_addr_i,
  output logic                ar_ready_o,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_rd_pkg::mgr_id_t r_id_o,
  output axi_rd_pkg::data_t   r_data_o,
  output axi_rd_pkg::resp_e   r_resp_o,
  ar_r_if.mgr                 sub_port [xbar_cfg_pkg::N_SUB],
  ar_r_if.mgr                 err_port
);

  logic dec_idx;
  logic dec_err;
  logic pend_q;     // A read is in flight
  logic tgt_err_q;  // In-flight read went to the error responder
  logic tgt_idx_q;  // Subordinate of the in-flight read
  logic ar_hs;
  logic r_hs;

  // Subordinate side signals gathered so they can be indexed
  logic [xbar_cfg_pkg::N_SUB-1:0]                      sub_ar_ready;
  logic [xbar_cfg_pkg::N_SUB-1:0]                      sub_r_valid;
  axi_rd_pkg::mgr_id_t [xbar_cfg_pkg::N_SUB-1:0]       sub_r_id;
  axi_rd_pkg::data_t   [xbar_cfg_pkg::N_SUB-1:0]       sub_r_data;
  axi_rd_pkg::resp_e   [xbar_cfg_pkg::N_SUB-1:0]       sub_r_resp;

  addr_decoder u_dec (
    .addr_i    (ar_addr_i),
    .sub_idx_o (dec_idx),
    .dec_err_o (dec_err)
  );

  for (genvar s = 0; s < xbar_cfg_pkg::N_SUB; s++) begin : g_sub
    assign sub_port[s].ar_valid = ar_valid_i && !pend_q && !dec_err && (dec_idx == 1'(s));
    assign sub_port[s].ar_id    = ar_id_i;
    assign sub_port[s].ar_addr  = ar_addr_i;
    assign sub_port[s].r_ready  = r_ready_i && pend_q && !tgt_err_q && (tgt_idx_q == 1'(s));

    assign sub_ar_ready[s] = sub_port[s].ar_ready;
    assign sub_r_valid[s]  = sub_port[s].r_valid;
    assign sub_r_id[s]     = sub_port[s].r_id;
    assign sub_r_data[s]   = sub_port[s].r_data;
    assign sub_r_resp[s]   = sub_port[s].r_resp;
  end

  // Unmapped addresses go to the error responder
  assign err_port.ar_valid = ar_valid_i && !pend_q && dec_err;
  assign err_port.ar_id    = ar_id_i;
  assign err_port.ar_addr  = ar_addr_i;
  assign err_port.r_ready  = r_ready_i && pend_q && tgt_err_q;

  assign ar_ready_o = !pend_q && (dec_err ? err_port.ar_ready : sub_ar_ready[dec_idx]);
  assign r_valid_o  = pend_q && (tgt_err_q ? err_port.r_valid : sub_r_valid[tgt_idx_q]);
  assign r_id_o     = tgt_err_q ? err_port.r_id   : sub_r_id[tgt_idx_q];
  assign r_data_o   = tgt_err_q ? err_port.r_data : sub_r_data[tgt_idx_q];
  assign r_resp_o   = tgt_err_q ? err_port.r_resp : sub_r_resp[tgt_idx_q];

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q    <= 1'b0;
      tgt_err_q <= 1'b0;
      tgt_idx_q <= 1'b0;
    end else if (ar_hs) begin
      pend_q    <= 1'b1;
      tgt_err_q <= dec_err;
      tgt_idx_q <= dec_idx;
    end else if (r_hs) begin
      pend_q <= 1'b0;  // Next AR may go in the following cycle
    end
  end

  // Only the target of the read in flight may offer an R beat
  for (genvar s = 0; s < xbar_cfg_pkg::N_SUB; s++) begin : g_r_chk
    a_r_from_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      sub_r_valid[s] |-> (pend_q && !tgt_err_q && (tgt_idx_q == 1'(s))))
      else $error("rd_demux: R beat offered by a subordinate with no read in flight");
  end

  a_err_r_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_port.r_valid |-> (pend_q && tgt_err_q))
    else $error("rd_demux: DECERR beat offered with no matching read in flight");

endmodule

// File: hw/err_responder.sv
// ========================================
// Decode error responder
// Answers each read with one DECERR beat
// ========================================

`timescale 1ns/1ns

module err_responder (
  input logic clk_i,
  input logic rst_n_i,
  ar_r_if.sub slv
);

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } state_e;

  state_e              state_q;
  axi_rd_pkg::mgr_id_t id_q;     // ID of the accepted read

  assign slv.ar_ready = (state_q == ST_IDLE);
  assign slv.r_valid  = (state_q == ST_RESP);
  assign slv.r_id     = id_q;
  assign slv.r_data   = '0;
  assign slv.r_resp   = axi_rd_pkg::DECERR;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (slv.ar_valid) state_q <= ST_RESP;
        ST_RESP: if (slv.r_ready)  state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv.ar_valid && slv.ar_ready) id_q <= slv.ar_id;
  end

  // The demux offers no new read while the DECERR beat waits
  a_no_ar_in_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv.r_valid |-> !slv.ar_valid)
    else $error("err_responder: AR offered while the DECERR beat was pending");

endmodule

// File: hw/rd_mux.sv
// ========================================
// Subordinate side read multiplexer
// Round-robin AR, ID extension, R return
// ========================================

`timescale 1ns/1ns

module rd_mux (
  input  logic                clk_i,
  input  logic                rst_n_i,
  ar_r_if.sub                 mgr_ports [xbar_cfg_pkg::N_MGR],
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  output axi_rd_pkg::sub_id_t ar_id_o,
  output axi_rd_pkg::addr_t   ar_addr_o,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  input  axi_rd_pkg::sub_id_t r_id_i,
  input  axi_rd_pkg::data_t   r_data_i,
  input  axi_rd_pkg::resp_e   r_resp_i
);

  // Manager side AR fields gathered so they can be indexed
  logic [xbar_cfg_pkg::N_MGR-1:0]                req;
  axi_rd_pkg::mgr_id_t [xbar_cfg_pkg::N_MGR-1:0] req_id;
  axi_rd_pkg::addr_t   [xbar_cfg_pkg::N_MGR-1:0] req_addr;
  logic [xbar_cfg_pkg::N_MGR-1:0]                mgr_r_ready;

  logic rr_q;    // Manager favored in the next arbitration
  logic lock_q;  // AR stalled, keep the grant
  logic gnt_q;
  logic sel;
  logic gnt;
  logic r_mgr;
  logic ar_hs;

  for (genvar m = 0; m < xbar_cfg_pkg::N_MGR; m++) begin : g_mgr
    assign req[m]         = mgr_ports[m].ar_valid;
    assign req_id[m]      = mgr_ports[m].ar_id;
    assign req_addr[m]    = mgr_ports[m].ar_addr;
    assign mgr_r_ready[m] = mgr_ports[m].r_ready;

    assign mgr_ports[m].ar_ready = ar_ready_i && (gnt == 1'(m));

    // R goes back to the manager named in the top ID bit
    assign mgr_ports[m].r_valid = r_valid_i && (r_mgr == 1'(m));
    assign mgr_ports[m].r_id    = r_id_i[xbar_cfg_pkg::MGR_ID_W-1:0];
    assign mgr_ports[m].r_data  = r_data_i;
    assign mgr_ports[m].r_resp  = r_resp_i;
  end

  // Favored manager wins unless only the other one requests
  assign sel = (req[rr_q] || !req[~rr_q]) ? rr_q : ~rr_q;
  assign gnt = lock_q ? gnt_q : sel;

  assign ar_valid_o = req[gnt];
  assign ar_id_o    = {gnt, req_id[gnt]};  // Manager index on top
  assign ar_addr_o  = req_addr[gnt];
  assign ar_hs      = ar_valid_o && ar_ready_i;

  assign r_mgr     = r_id_i[xbar_cfg_pkg::SUB_ID_W-1];
  assign r_ready_o = mgr_r_ready[r_mgr];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q   <= 1'b0;
      lock_q <= 1'b0;
      gnt_q  <= 1'b0;
    end else begin
      lock_q <= ar_valid_o && !ar_ready_i;
      gnt_q  <= gnt;
      if (ar_hs) begin
        rr_q <= gnt + 1'b1;  // Move past the winner
      end
    end
  end

  // Stalled AR keeps its manager and payload until the subordinate takes it
  a_grant_locked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ar_valid_o && !ar_ready_i) |=>
      (ar_valid_o && $stable(ar_id_o) && $stable(ar_addr_o)))
    else $error("rd_mux: AR dropped or changed while waiting for ready");

endmodule

// File: hw/xbar_top.sv
// ========================================
// Two by two AXI read crossbar
// ========================================

`timescale 1ns/1ns

module xbar_top (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Manager ports
  input  logic [xbar_cfg_pkg::N_MGR-1:0]                mgr_ar_valid_i,
  output logic [xbar_cfg_pkg::N_MGR-1:0]                mgr_ar_ready_o,
  input  axi_rd_pkg::mgr_id_t [xbar_cfg_pkg::N_MGR-1:0] mgr_ar_id_i,
  input  axi_rd_pkg::addr_t   [xbar_cfg_pkg::N_MGR-1:0] mgr_ar_addr_i,
  output logic [xbar_cfg_pkg::N_MGR-1:0]                mgr_r_valid_o,
  input  logic [xbar_cfg_pkg::N_MGR-1:0]                mgr_r_ready_i,
  output axi_rd_pkg::mgr_id_t [xbar_cfg_pkg::N_MGR-1:0] mgr_r_id_o,
  output axi_rd_pkg::data_t   [xbar_cfg_pkg::N_MGR-1:0] mgr_r_data_o,
  output axi_rd_pkg::resp_e   [xbar_cfg_pkg::N_MGR-1:0] mgr_r_resp_o,
  // Subordinate ports
  output logic [xbar_cfg_pkg::N_SUB-1:0]                sub_ar_valid_o,
  input  logic [xbar_cfg_pkg::N_SUB-1:0]                sub_ar_ready_i,
  output axi_rd_pkg::sub_id_t [xbar_cfg_pkg::N_SUB-1:0] sub_ar_id_o,
  output axi_rd_pkg::addr_t   [xbar_cfg_pkg::N_SUB-1:0] sub_ar_addr_o,
  input  logic [xbar_cfg_pkg::N_SUB-1:0]                sub_r_valid_i,
  output logic [xbar_cfg_pkg::N_SUB-1:0]                sub_r_ready_o,
  input  axi_rd_pkg::sub_id_t [xbar_cfg_pkg::N_SUB-1:0] sub_r_id_i,
  input  axi_rd_pkg::data_t   [xbar_cfg_pkg::N_SUB-1:0] sub_r_data_i,
  input  axi_rd_pkg::resp_e   [xbar_cfg_pkg::N_SUB-1:0] sub_r_resp_i
);

  for (genvar m = 0; m < xbar_cfg_pkg::N_MGR; m++) begin : g_mgr
    ar_r_if #(.ID_W(xbar_cfg_pkg::MGR_ID_W)) sub_if [xbar_cfg_pkg::N_SUB] ();
    ar_r_if #(.ID_W(xbar_cfg_pkg::MGR_ID_W)) err_if ();

    rd_demux u_demux (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ar_valid_i (mgr_ar_valid_i[m]),
      .ar_id_i    (mgr_ar_id_i[m]),
      .ar_addr_i  (mgr_ar_addr_i[m]),
      .ar_ready_o (mgr_ar_ready_o[m]),
      .r_valid_o  (mgr_r_valid_o[m]),
      .r_ready_i  (mgr_r_ready_i[m]),
      .r_id_o     (mgr_r_id_o[m]),
      .r_data_o   (mgr_r_data_o[m]),
      .r_resp_o   (mgr_r_resp_o[m]),
      .sub_port   (sub_if),
      .err_port   (err_if)
    );

    err_responder u_err (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .slv     (err_if)
    );
  end

  for (genvar s = 0; s < xbar_cfg_pkg::N_SUB; s++) begin : g_sub
    ar_r_if #(.ID_W(xbar_cfg_pkg::MGR_ID_W)) mgr_if [xbar_cfg_pkg::N_MGR] ();

    rd_mux u_mux (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .mgr_ports  (mgr_if),
      .ar_valid_o (sub_ar_valid_o[s]),
      .ar_ready_i (sub_ar_ready_i[s]),
      .ar_id_o    (sub_ar_id_o[s]),
      .ar_addr_o  (sub_ar_addr_o[s]),
      .r_valid_i  (sub_r_valid_i[s]),
      .r_ready_o  (sub_r_ready_o[s]),
      .r_id_i     (sub_r_id_i[s]),
      .r_data_i   (sub_r_data_i[s]),
      .r_resp_i   (sub_r_resp_i[s])
    );
  end

  // Crossing, demux m port s meets mux s port m
  for (genvar m = 0; m < xbar_cfg_pkg::N_MGR; m++) begin : g_cross_m
    for (genvar s = 0; s < xbar_cfg_pkg::N_SUB; s++) begin : g_cross_s
      assign g_sub[s].mgr_if[m].ar_valid = g_mgr[m].sub_if[s].ar_valid;
      assign g_sub[s].mgr_if[m].ar_id    = g_mgr[m].sub_if[s].ar_id;
      assign g_sub[s].mgr_if[m].ar_addr  = g_mgr[m].sub_if[s].ar_addr;
      assign g_sub[s].mgr_if[m].r_ready  = g_mgr[m].sub_if[s].r_ready;
      assign g_mgr[m].sub_if[s].ar_ready = g_sub[s].mgr_if[m].ar_ready;
      assign g_mgr[m].sub_if[s].r_valid  = g_sub[s].mgr_if[m].r_valid;
      assign g_mgr[m].sub_if[s].r_id     = g_sub[s].mgr_if[m].r_id;
      assign g_mgr[m].sub_if[s].r_data   = g_sub[s].mgr_if[m].r_data;
      assign g_mgr[m].sub_if[s].r_resp   = g_sub[s].mgr_if[m].r_resp;
    end
  end

endmodule

// File: verif/tb_xbar.sv
// ========================================
// Directed testbench for the read crossbar
// ========================================

`timescale 1ns/1ns

module tb_xbar;

  localparam int TIMEOUT = 50;

  logic clk_i = 1'b0;
  logic rst_n_i = 1'b0;
  int   cyc = 0;

  logic [1:0] mgr_ar_valid_i;
  logic [1:0] mgr_ar_ready_o;
  axi_rd_pkg::mgr_id_t [1:0] mgr_ar_id_i;
  axi_rd_pkg::addr_t   [1:0] mgr_ar_addr_i;
  logic [1:0] mgr_r_valid_o;
  logic [1:0] mgr_r_ready_i;
  axi_rd_pkg::mgr_id_t [1:0] mgr_r_id_o;
  axi_rd_pkg::data_t   [1:0] mgr_r_data_o;
  axi_rd_pkg::resp_e   [1:0] mgr_r_resp_o;
  logic [1:0] sub_ar_valid_o;
  logic [1:0] sub_ar_ready_i = '0;
  axi_rd_pkg::sub_id_t [1:0] sub_ar_id_o;
  axi_rd_pkg::addr_t   [1:0] sub_ar_addr_o;
  logic [1:0] sub_r_valid_i = '0;
  logic [1:0] sub_r_ready_o;
  axi_rd_pkg::sub_id_t [1:0] sub_r_id_i = '0;
  axi_rd_pkg::data_t   [1:0] sub_r_data_i = '0;
  axi_rd_pkg::resp_e   [1:0] sub_r_resp_i = {axi_rd_pkg::OKAY, axi_rd_pkg::OKAY};

  // Subordinate model state
  logic [1:0]                busy = '0;
  logic [1:0]                delay [2];
  axi_rd_pkg::sub_id_t [1:0] req_id;
  axi_rd_pkg::addr_t   [1:0] req_addr;
  logic [31:0]               lfsr_q = 32'h0419_129f;
  logic [3:0]                ar_log [$];  // {subordinate, sub side ID}

  xbar_top uut (.*);

  initial begin
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [31:0] sub_tag(input logic s);
    return s ? 32'h5A5A_0000 : 32'hA5A5_0000;
  endfunction

  // One cycle of one subordinate model, random latency of 0 to 3 cycles
  task automatic model_step(input logic s);
    logic b0;
    logic b1;
    if (sub_ar_valid_o[s] && sub_ar_ready_i[s]) begin
      b0 = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
      b1 = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
      sub_ar_ready_i[s] <= 1'b0;
      busy[s]           <= 1'b1;
      delay[s]          <= {b1, b0};
      req_id[s]         <= sub_ar_id_o[s];
      req_addr[s]       <= sub_ar_addr_o[s];
      ar_log.push_back({s, sub_ar_id_o[s]});
    end else if (busy[s] && !sub_r_valid_i[s]) begin
      if (delay[s] == 2'd0) begin
        sub_r_valid_i[s] <= 1'b1;
        sub_r_id_i[s]    <= req_id[s];
        sub_r_data_i[s]  <= req_addr[s] ^ sub_tag(s);
        sub_r_resp_i[s]  <= axi_rd_pkg::OKAY;
      end else begin
        delay[s] <= delay[s] - 2'd1;
      end
    end else if (sub_r_valid_i[s] && sub_r_ready_o[s]) begin
      sub_r_valid_i[s]  <= 1'b0;
      busy[s]           <= 1'b0;
      sub_ar_ready_i[s] <= 1'b1;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      sub_ar_ready_i <= '1;
      sub_r_valid_i  <= '0;
      busy           <= '0;
    end else begin
      model_step(1'b0);
      model_step(1'b1);
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  task automatic drive_ar(input logic m, input axi_rd_pkg::mgr_id_t id,
                          input axi_rd_pkg::addr_t addr);
    @(posedge clk_i);
    mgr_ar_valid_i[m] <= 1'b1;
    mgr_ar_id_i[m]    <= id;
    mgr_ar_addr_i[m]  <= addr;
  endtask

  task automatic wait_ar_hs(input logic m, output int cyc_o);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT) abort_run($sformatf("Manager %0d AR was never accepted", m));
    end while (!(mgr_ar_valid_i[m] && mgr_ar_ready_o[m]));
    cyc_o = cyc;
    mgr_ar_valid_i[m] <= 1'b0;
  endtask

  task automatic wait_r_hs(input logic m, output logic [31:0] data, output logic [1:0] id,
                           output logic [1:0] resp, output int cyc_o);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT) abort_run($sformatf("Manager %0d never got its R beat", m));
    end while (!(mgr_r_valid_o[m] && mgr_r_ready_i[m]));
    data  = mgr_r_data_o[m];
    id    = mgr_r_id_o[m];
    resp  = mgr_r_resp_o[m];
    cyc_o = cyc;
  endtask

  // Full read to a mapped address, checked against the model's rule
  task automatic read_one(input logic m, input logic [1:0] id, input logic [31:0] addr,
                          input logic s);
    int          ca;
    int          cr;
    logic [31:0] data;
    logic [1:0]  rid;
    logic [1:0]  resp;
    drive_ar(m, id, addr);
    wait_ar_hs(m, ca);
    wait_r_hs(m, data, rid, resp, cr);
    check("mgr_r_data_o", data, addr ^ sub_tag(s));
    check("mgr_r_resp_o", 32'(resp), 32'(axi_rd_pkg::OKAY));
    check("mgr_r_id_o", 32'(rid), 32'(id));
  endtask

  task automatic mapped_reads();
    read_one(1'b0, 2'd1, 32'h0000_1234, 1'b0);
    read_one(1'b0, 2'd2, 32'h0001_0ABC, 1'b1);
    read_one(1'b1, 2'd3, 32'h0000_FFFC, 1'b0);
    read_one(1'b1, 2'd0, 32'h0001_FFF0, 1'b1);
  endtask

  task automatic decode_error();
    int          ca;
    int          cr;
    int          n_log;
    logic [31:0] data;
    logic [1:0]  rid;
    logic [1:0]  resp;
    n_log = ar_log.size();
    drive_ar(1'b1, 2'd2, 32'h0002_0000);
    wait_ar_hs(1'b1, ca);
    wait_r_hs(1'b1, data, rid, resp, cr);
    check("mgr_r_resp_o", 32'(resp), 32'(axi_rd_pkg::DECERR));
    check("mgr_r_data_o", data, 32'h0);
    check("mgr_r_id_o", 32'(rid), 32'd2);
    check("r_valid delay", 32'(cr - ca), 32'd1);
    check("sub AR count", 32'(ar_log.size()), 32'(n_log));
  endtask

  // Manager index lands in the top ID bit at the subordinate
  task automatic id_extension();
    read_one(1'b1, 2'd2, 32'h0000_0100, 1'b0);
    check("sub_ar_id_o", 32'(ar_log[ar_log.size() - 1]), 32'b0_110);
    read_one(1'b0, 2'd3, 32'h0001_0200, 1'b1);
    check("sub_ar_id_o", 32'(ar_log[ar_log.size() - 1]), 32'b1_011);
  endtask

  task automatic contention();
    int n_log;
    apply_reset();
    n_log = ar_log.size();
    fork
      read_one(1'b0, 2'd1, 32'h0001_0010, 1'b1);
      read_one(1'b1, 2'd2, 32'h0001_0020, 1'b1);
    join
    check("sub AR count", 32'(ar_log.size()), 32'(n_log + 2));
    check("first sub_ar_id_o", 32'(ar_log[n_log]), 32'b1_001);
    check("second sub_ar_id_o", 32'(ar_log[n_log + 1]), 32'b1_110);
  endtask

  task automatic back_pressure();
    int          ca;
    int          cr;
    int          n;
    logic [31:0] held;
    logic [31:0] data;
    logic [1:0]  rid;
    logic [1:0]  resp;
    drive_ar(1'b0, 2'd1, 32'h0000_0040);
    mgr_r_ready_i[0] <= 1'b0;
    wait_ar_hs(1'b0, ca);
    drive_ar(1'b0, 2'd2, 32'h0000_0080);  // Second AR waits behind the first
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT) abort_run("Manager 0 R beat never became valid under back-pressure");
    end while (!mgr_r_valid_o[0]);
    held = mgr_r_data_o[0];
    check("mgr_r_data_o", held, 32'h0000_0040 ^ sub_tag(1'b0));
    repeat (4) begin
      @(posedge clk_i);
      check("mgr_r_valid_o", 32'(mgr_r_valid_o[0]), 32'd1);
      check("mgr_r_data_o", mgr_r_data_o[0], held);
      check("mgr_ar_ready_o", 32'(mgr_ar_ready_o[0]), 32'd0);
    end
    mgr_r_ready_i[0] <= 1'b1;
    wait_r_hs(1'b0, data, rid, resp, cr);
    check("mgr_r_id_o", 32'(rid), 32'd1);
    wait_ar_hs(1'b0, ca);
    wait_r_hs(1'b0, data, rid, resp, cr);
    check("mgr_r_data_o", data, 32'h0000_0080 ^ sub_tag(1'b0));
    check("mgr_r_id_o", 32'(rid), 32'd2);
  endtask

  initial begin
    mgr_ar_valid_i = '0;
    mgr_ar_id_i    = '0;
    mgr_ar_addr_i  = '0;
    mgr_r_ready_i  = '1;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    mapped_reads();
    decode_error();
    id_extension();
    contention();
    back_pressure();
    repeat (2) @(posedge clk_i);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: build.f
hw/xbar_cfg_pkg.sv
hw/axi_rd_pkg.sv
hw/ar_r_if.sv
hw/addr_decoder.sv
hw/rd_demux.sv
hw/err_responder.sv
hw/rd_mux.sv
hw/xbar_top.sv
verif/tb_xbar.sv

// File: Makefile
# Verilator build and run for the AXI read crossbar

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_xbar
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_STR  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
